//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int DATA_W    = 32;
    localparam int REG_ADR_W = 5;
    localparam int ALU_OP_W  = 3;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // Opcodes and function codes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    localparam logic [DATA_W-1:0] IO_BASE  = 32'hFFFF_FC00;    // Top 1 KB is IO
    localparam logic [DATA_W-1:0] LED_ADDR = 32'hFFFF_FC60;    // Low half, +2 is high byte

    typedef struct packed {
        logic [5:0]           opcode;
        logic [REG_ADR_W-1:0] rs;
        logic [REG_ADR_W-1:0] rt;
        logic [REG_ADR_W-1:0] rd;
        logic [4:0]           shamt;
        logic [5:0]           funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [REG_ADR_W-1:0] rs;
        logic [REG_ADR_W-1:0] rt;
        logic [15:0]          imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

//--- fetch/ifetch.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch
    import mips_pkg::*;
#(
    parameter int IMEM_ADR_W = 8
)(
    input  wire                   fpga_clk,
    input  wire                   cpu_rst_i,
    input  wire                   prog_mode_i,
    input  wire                   prog_wen_i,
    input  wire  [IMEM_ADR_W-1:0] prog_adr_i,
    input  wire  [DATA_W-1:0]     prog_dat_i,
    input  wire                   stall_i,
    input  wire                   flush_i,
    input  wire  [DATA_W-1:0]     branch_target_i,
    output instr_u                ifid_instr_o,
    output logic [DATA_W-1:0]     ifid_pc4_o
);

    logic [DATA_W-1:0] imem [2**IMEM_ADR_W];
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] pc4;

    assign pc4 = pc + 32'd4;

    always_ff @(posedge fpga_clk)
    begin
        if (prog_mode_i && prog_wen_i)
            imem[prog_adr_i] <= prog_dat_i;
    end

    always_ff @(posedge fpga_clk)
    begin
        if (cpu_rst_i)
            pc <= '0;
        else if (flush_i)
            pc <= branch_target_i;                             // Taken branch wins over stall
        else if (!stall_i)
            pc <= pc4;
    end

    always_ff @(posedge fpga_clk)
    begin
        if (cpu_rst_i || flush_i)
        begin
            ifid_instr_o <= '0;
            ifid_pc4_o   <= '0;
        end
        else if (!stall_i)
        begin
            ifid_instr_o <= imem[pc[IMEM_ADR_W+1:2]];          // Word addressed
            ifid_pc4_o   <= pc4;
        end
    end

endmodule

`default_nettype wire

//--- decode/idecode.sv
`timescale 1ns/1ps
`default_nettype none

module idecode
    import mips_pkg::*;
(
    input  wire                  fpga_clk,
    input  wire                  cpu_rst_i,
    input  wire instr_u          ifid_instr_i,
    input  wire [DATA_W-1:0]     ifid_pc4_i,
    input  wire                  flush_i,
    input  wire                  wb_en_i,
    input  wire [REG_ADR_W-1:0]  wb_adr_i,
    input  wire [DATA_W-1:0]     wb_data_i,
    output logic [DATA_W-1:0]    idex_op_a_o,
    output logic [DATA_W-1:0]    idex_op_b_o,
    output logic [DATA_W-1:0]    idex_imm_o,
    output logic [DATA_W-1:0]    idex_target_o,
    output logic [REG_ADR_W-1:0] idex_rs_o,
    output logic [REG_ADR_W-1:0] idex_rt_o,
    output logic [REG_ADR_W-1:0] idex_dest_o,
    output alu_op_t              idex_alu_op_o,
    output logic                 idex_reg_wen_o,
    output logic                 idex_mem_rd_o,
    output logic                 idex_mem_wr_o,
    output logic                 idex_itype_o,
    output logic                 idex_beq_o,
    output logic                 idex_bne_o,
    output logic                 stall_o
);

    logic [DATA_W-1:0]    regs [2**REG_ADR_W];
    logic [REG_ADR_W-1:0] rs, rt, dest;
    logic [DATA_W-1:0]    imm_sext, imm_ext, rd_a, rd_b;
    alu_op_t              alu_op;
    logic                 reg_wen, mem_rd, mem_wr, itype, beq, bne, zext;

    assign rs       = ifid_instr_i.r.rs;
    assign rt       = ifid_instr_i.r.rt;
    assign imm_sext = {{16{ifid_instr_i.i.imm[15]}}, ifid_instr_i.i.imm};
    assign imm_ext  = zext ? {16'b0, ifid_instr_i.i.imm} : imm_sext;

    ////////////////////////////////////////////////////////////
    // Control decode
    always_comb
    begin
        reg_wen = 1'b0;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        itype   = 1'b0;
        beq     = 1'b0;
        bne     = 1'b0;
        zext    = 1'b0;
        alu_op  = ALU_ADD;
        dest    = rt;
        case (ifid_instr_i.r.opcode)
            OP_RTYPE:
            begin
                dest    = ifid_instr_i.r.rd;
                reg_wen = 1'b1;
                case (ifid_instr_i.r.funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_wen = 1'b0;                   // Unsupported funct is a nop
                endcase
            end
            OP_ADDI: {reg_wen, itype} = 2'b11;
            OP_ANDI: {reg_wen, itype, zext, alu_op} = {3'b111, ALU_AND};
            OP_ORI:  {reg_wen, itype, zext, alu_op} = {3'b111, ALU_OR};
            OP_LW:   {reg_wen, itype, mem_rd} = 3'b111;
            OP_SW:   {itype, mem_wr} = 2'b11;
            OP_BEQ:  beq = 1'b1;
            OP_BNE:  bne = 1'b1;
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Register file, write before read
    always_ff @(posedge fpga_clk)
    begin
        if (wb_en_i && wb_adr_i != '0)
            regs[wb_adr_i] <= wb_data_i;
    end

    assign rd_a = (rs == '0) ? '0 :
                  (wb_en_i && wb_adr_i == rs) ? wb_data_i : regs[rs];
    assign rd_b = (rt == '0) ? '0 :
                  (wb_en_i && wb_adr_i == rt) ? wb_data_i : regs[rt];

    // Load in ID/EX feeding the instruction behind it
    assign stall_o = idex_mem_rd_o && (idex_dest_o != '0) &&
                     (idex_dest_o == rs || idex_dest_o == rt);

    always_ff @(posedge fpga_clk)
    begin
        if (cpu_rst_i || flush_i || stall_o)
        begin
            idex_reg_wen_o <= 1'b0;                            // Bubble
            idex_mem_rd_o  <= 1'b0;
            idex_mem_wr_o  <= 1'b0;
            idex_itype_o   <= 1'b0;
            idex_beq_o     <= 1'b0;
            idex_bne_o     <= 1'b0;
        end
        else
        begin
            idex_reg_wen_o <= reg_wen;
            idex_mem_rd_o  <= mem_rd;
            idex_mem_wr_o  <= mem_wr;
            idex_itype_o   <= itype;
            idex_beq_o     <= beq;
            idex_bne_o     <= bne;
        end
    end

    always_ff @(posedge fpga_clk)
    begin
        idex_op_a_o   <= rd_a;
        idex_op_b_o   <= rd_b;
        idex_imm_o    <= imm_ext;
        idex_target_o <= ifid_pc4_i + {imm_sext[DATA_W-3:0], 2'b00};
        idex_rs_o     <= rs;
        idex_rt_o     <= rt;
        idex_dest_o   <= dest;
        idex_alu_op_o <= alu_op;
    end

endmodule

`default_nettype wire

//--- execute/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute
    import mips_pkg::*;
(
    input  wire                  fpga_clk,
    input  wire                  cpu_rst_i,
    input  wire [DATA_W-1:0]     idex_op_a_i,
    input  wire [DATA_W-1:0]     idex_op_b_i,
    input  wire [DATA_W-1:0]     idex_imm_i,
    input  wire [DATA_W-1:0]     idex_target_i,
    input  wire [REG_ADR_W-1:0]  idex_rs_i,
    input  wire [REG_ADR_W-1:0]  idex_rt_i,
    input  wire [REG_ADR_W-1:0]  idex_dest_i,
    input  wire alu_op_t         idex_alu_op_i,
    input  wire                  idex_reg_wen_i,
    input  wire                  idex_mem_rd_i,
    input  wire                  idex_mem_wr_i,
    input  wire                  idex_itype_i,
    input  wire                  idex_beq_i,
    input  wire                  idex_bne_i,
    input  wire                  exmem_fwd_en_i,
    input  wire [REG_ADR_W-1:0]  exmem_fwd_adr_i,
    input  wire                  wb_en_i,
    input  wire [REG_ADR_W-1:0]  wb_adr_i,
    input  wire [DATA_W-1:0]     wb_data_i,
    output logic [DATA_W-1:0]    exmem_result_o,
    output logic [DATA_W-1:0]    exmem_store_o,
    output logic [REG_ADR_W-1:0] exmem_dest_o,
    output logic                 exmem_reg_wen_o,
    output logic                 exmem_mem_rd_o,
    output logic                 exmem_mem_wr_o,
    output logic                 flush_o,
    output logic [DATA_W-1:0]    branch_target_o
);

    logic [DATA_W-1:0] fwd_a, fwd_b, alu_b, alu_y;
    logic              taken;
    logic              exmem_taken;

    // EX/MEM first, then MEM/WB, never for r0
    function automatic logic [DATA_W-1:0] fwd_sel(
        input logic [REG_ADR_W-1:0] adr,
        input logic [DATA_W-1:0]    reg_val
    );
        if (exmem_fwd_en_i && exmem_fwd_adr_i != '0 && exmem_fwd_adr_i == adr)
            return exmem_result_o;
        else if (wb_en_i && wb_adr_i != '0 && wb_adr_i == adr)
            return wb_data_i;
        else
            return reg_val;
    endfunction

    always_comb
    begin
        fwd_a = fwd_sel(idex_rs_i, idex_op_a_i);
        fwd_b = fwd_sel(idex_rt_i, idex_op_b_i);
    end

    assign alu_b = idex_itype_i ? idex_imm_i : fwd_b;

    always_comb
    begin
        case (idex_alu_op_i)
            ALU_SUB: alu_y = fwd_a - alu_b;
            ALU_AND: alu_y = fwd_a & alu_b;
            ALU_OR:  alu_y = fwd_a | alu_b;
            ALU_SLT: alu_y = {31'b0, $signed(fwd_a) < $signed(alu_b)};
            default: alu_y = fwd_a + alu_b;
        endcase
    end

    assign taken = (idex_beq_i && fwd_a == fwd_b) || (idex_bne_i && fwd_a != fwd_b);

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    always_ff @(posedge fpga_clk)
    begin
        if (cpu_rst_i || flush_o)
        begin
            exmem_reg_wen_o <= 1'b0;
            exmem_mem_rd_o  <= 1'b0;
            exmem_mem_wr_o  <= 1'b0;
            exmem_taken     <= 1'b0;
        end
        else
        begin
            exmem_reg_wen_o <= idex_reg_wen_i;
            exmem_mem_rd_o  <= idex_mem_rd_i;
            exmem_mem_wr_o  <= idex_mem_wr_i;
            exmem_taken     <= taken;
        end
    end

    always_ff @(posedge fpga_clk)
    begin
        exmem_result_o  <= alu_y;
        exmem_store_o   <= fwd_b;
        exmem_dest_o    <= idex_dest_i;
        branch_target_o <= idex_target_i;
    end

    assign flush_o = exmem_taken;                              // Kills the three younger ones

endmodule

`default_nettype wire

//--- memory/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import mips_pkg::*;
#(
    parameter int DMEM_ADR_W = 8
)(
    input  wire                  fpga_clk,
    input  wire                  cpu_rst_i,
    input  wire [DATA_W-1:0]     exmem_result_i,
    input  wire [DATA_W-1:0]     exmem_store_i,
    input  wire [REG_ADR_W-1:0]  exmem_dest_i,
    input  wire                  exmem_reg_wen_i,
    input  wire                  exmem_mem_rd_i,
    input  wire                  exmem_mem_wr_i,
    output logic                 led_wen_o,
    output logic                 led_hi_o,
    output logic [15:0]          led_data_o,
    output logic                 wb_en_o,
    output logic [REG_ADR_W-1:0] wb_adr_o,
    output logic [DATA_W-1:0]    wb_data_o
);

    logic [DATA_W-1:0]     ram [2**DMEM_ADR_W];
    logic [DMEM_ADR_W-1:0] ram_adr;
    logic                  is_io;
    logic [DATA_W-1:0]     load_data;
    logic                  memwb_ld;
    logic [DATA_W-1:0]     memwb_load;
    logic [DATA_W-1:0]     memwb_result;

    assign is_io     = exmem_result_i >= IO_BASE;
    assign ram_adr   = exmem_result_i[DMEM_ADR_W+1:2];
    assign load_data = is_io ? '0 : ram[ram_adr];              // IO reads as zero

    always_ff @(posedge fpga_clk)
    begin
        if (exmem_mem_wr_i && !is_io)
            ram[ram_adr] <= exmem_store_i;
    end

    ////////////////////////////////////////////////////////////
    // LED decode
    assign led_hi_o   = exmem_result_i == LED_ADDR + 32'd2;
    assign led_wen_o  = exmem_mem_wr_i && (exmem_result_i == LED_ADDR || led_hi_o);
    assign led_data_o = exmem_store_i[15:0];

    always_ff @(posedge fpga_clk)
    begin
        if (cpu_rst_i)
        begin
            wb_en_o  <= 1'b0;
            memwb_ld <= 1'b0;
        end
        else
        begin
            wb_en_o  <= exmem_reg_wen_i;
            memwb_ld <= exmem_mem_rd_i;
        end
    end

    always_ff @(posedge fpga_clk)
    begin
        wb_adr_o     <= exmem_dest_i;
        memwb_load   <= load_data;
        memwb_result <= exmem_result_i;
    end

    assign wb_data_o = memwb_ld ? memwb_load : memwb_result;

endmodule

`default_nettype wire

//--- hw/led_port.sv
`timescale 1ns/1ps
`default_nettype none

module led_port (
    input  wire         fpga_clk,
    input  wire         cpu_rst_i,
    input  wire         led_wen_i,
    input  wire         led_hi_i,
    input  wire  [15:0] led_data_i,
    output logic [23:0] led_o
);

    always_ff @(posedge fpga_clk)
    begin
        if (cpu_rst_i)
            led_o <= '0;
        else if (led_wen_i)
        begin
            if (led_hi_i)
                led_o[23:16] <= led_data_i[7:0];               // Low byte of the word only
            else
                led_o[15:0] <= led_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/mips_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline_top
    import mips_pkg::*;
#(
    parameter int IMEM_ADR_W = 8,
    parameter int DMEM_ADR_W = 8
)(
    input  wire                  fpga_clk,
    input  wire                  fpga_rst,
    input  wire                  prog_mode_i,
    input  wire                  prog_wen_i,
    input  wire [IMEM_ADR_W-1:0] prog_adr_i,
    input  wire [DATA_W-1:0]     prog_dat_i,
    output wire [23:0]           led_o
);

    logic                 cpu_rst;
    instr_u               ifid_instr;
    logic [DATA_W-1:0]    ifid_pc4;
    logic                 stall;
    logic                 flush;
    logic [DATA_W-1:0]    branch_target;

    logic [DATA_W-1:0]    idex_op_a, idex_op_b, idex_imm, idex_target;
    logic [REG_ADR_W-1:0] idex_rs, idex_rt, idex_dest;
    alu_op_t              idex_alu_op;
    logic                 idex_reg_wen, idex_mem_rd, idex_mem_wr;
    logic                 idex_itype, idex_beq, idex_bne;

    logic [DATA_W-1:0]    exmem_result, exmem_store;
    logic [REG_ADR_W-1:0] exmem_dest;
    logic                 exmem_reg_wen, exmem_mem_rd, exmem_mem_wr;

    logic                 wb_en;
    logic [REG_ADR_W-1:0] wb_adr;
    logic [DATA_W-1:0]    wb_data;

    logic                 led_wen, led_hi;
    logic [15:0]          led_data;

    always_ff @(posedge fpga_clk)
    begin
        cpu_rst <= fpga_rst || prog_mode_i;                    // Held in reset while loading
    end

    ////////////////////////////////////////////////////////////
    ifetch #(.IMEM_ADR_W(IMEM_ADR_W)) u_ifetch (
        .fpga_clk(fpga_clk), .cpu_rst_i(cpu_rst),
        .prog_mode_i(prog_mode_i), .prog_wen_i(prog_wen_i),
        .prog_adr_i(prog_adr_i), .prog_dat_i(prog_dat_i),
        .stall_i(stall), .flush_i(flush), .branch_target_i(branch_target),
        .ifid_instr_o(ifid_instr), .ifid_pc4_o(ifid_pc4)
    );

    idecode u_idecode (
        .fpga_clk(fpga_clk), .cpu_rst_i(cpu_rst),
        .ifid_instr_i(ifid_instr), .ifid_pc4_i(ifid_pc4), .flush_i(flush),
        .wb_en_i(wb_en), .wb_adr_i(wb_adr), .wb_data_i(wb_data),
        .idex_op_a_o(idex_op_a), .idex_op_b_o(idex_op_b),
        .idex_imm_o(idex_imm), .idex_target_o(idex_target),
        .idex_rs_o(idex_rs), .idex_rt_o(idex_rt), .idex_dest_o(idex_dest),
        .idex_alu_op_o(idex_alu_op), .idex_reg_wen_o(idex_reg_wen),
        .idex_mem_rd_o(idex_mem_rd), .idex_mem_wr_o(idex_mem_wr),
        .idex_itype_o(idex_itype), .idex_beq_o(idex_beq), .idex_bne_o(idex_bne),
        .stall_o(stall)
    );

    execute u_execute (
        .fpga_clk(fpga_clk), .cpu_rst_i(cpu_rst),
        .idex_op_a_i(idex_op_a), .idex_op_b_i(idex_op_b),
        .idex_imm_i(idex_imm), .idex_target_i(idex_target),
        .idex_rs_i(idex_rs), .idex_rt_i(idex_rt), .idex_dest_i(idex_dest),
        .idex_alu_op_i(idex_alu_op), .idex_reg_wen_i(idex_reg_wen),
        .idex_mem_rd_i(idex_mem_rd), .idex_mem_wr_i(idex_mem_wr),
        .idex_itype_i(idex_itype), .idex_beq_i(idex_beq), .idex_bne_i(idex_bne),
        .exmem_fwd_en_i(exmem_reg_wen), .exmem_fwd_adr_i(exmem_dest),
        .wb_en_i(wb_en), .wb_adr_i(wb_adr), .wb_data_i(wb_data),
        .exmem_result_o(exmem_result), .exmem_store_o(exmem_store),
        .exmem_dest_o(exmem_dest), .exmem_reg_wen_o(exmem_reg_wen),
        .exmem_mem_rd_o(exmem_mem_rd), .exmem_mem_wr_o(exmem_mem_wr),
        .flush_o(flush), .branch_target_o(branch_target)
    );

    mem_stage #(.DMEM_ADR_W(DMEM_ADR_W)) u_mem_stage (
        .fpga_clk(fpga_clk), .cpu_rst_i(cpu_rst),
        .exmem_result_i(exmem_result), .exmem_store_i(exmem_store),
        .exmem_dest_i(exmem_dest), .exmem_reg_wen_i(exmem_reg_wen),
        .exmem_mem_rd_i(exmem_mem_rd), .exmem_mem_wr_i(exmem_mem_wr),
        .led_wen_o(led_wen), .led_hi_o(led_hi), .led_data_o(led_data),
        .wb_en_o(wb_en), .wb_adr_o(wb_adr), .wb_data_o(wb_data)
    );

    led_port u_led_port (
        .fpga_clk(fpga_clk), .cpu_rst_i(cpu_rst),
        .led_wen_i(led_wen), .led_hi_i(led_hi), .led_data_i(led_data),
        .led_o(led_o)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 2
)(
    output logic fpga_clk,
    output logic fpga_rst
);

    initial
    begin
        fpga_clk = 1'b0;
        forever #(PERIOD_NS / 2) fpga_clk = ~fpga_clk;
    end

    initial
    begin
        fpga_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge fpga_clk);
        fpga_rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- test/tb_mips.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips;

    localparam int IMEM_ADR_W     = 8;
    localparam int DMEM_ADR_W     = 8;
    localparam int RST_TIMEOUT    = 10;
    localparam int CHANGE_TIMEOUT = 200;
    localparam int STEADY_CYCLES  = 100;

    logic                  fpga_clk;
    logic                  fpga_rst;
    logic                  prog_mode_i;
    logic                  prog_wen_i;
    logic [IMEM_ADR_W-1:0] prog_adr_i;
    logic [31:0]           prog_dat_i;
    wire  [23:0]           led_o;

    logic [31:0] prog_adr_q[$];
    logic [31:0] prog_word_q[$];
    logic [31:0] led_exp_q[$];

    int   mismatch_cnt = 0;
    int   timeout_cnt  = 0;
    int   other_cnt    = 0;
    logic aborted      = 1'b0;

    tb_clock #(.PERIOD_NS(20), .RST_CYCLES(2)) u_clock (
        .fpga_clk(fpga_clk),
        .fpga_rst(fpga_rst)
    );

    mips_pipeline_top #(.IMEM_ADR_W(IMEM_ADR_W), .DMEM_ADR_W(DMEM_ADR_W)) DUT (
        .fpga_clk(fpga_clk), .fpga_rst(fpga_rst),
        .prog_mode_i(prog_mode_i), .prog_wen_i(prog_wen_i),
        .prog_adr_i(prog_adr_i), .prog_dat_i(prog_dat_i),
        .led_o(led_o)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            mismatch_cnt++;
            $display("CHECK FAILED at %0d ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1)
            ch = $fgetc(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // P lines carry program words and L lines the LED values
    task automatic read_trace();
        int          fd;
        int          n;
        logic [7:0]  tag;
        logic [31:0] a;
        logic [31:0] b;
        logic        done;
        fd = $fopen("test/program_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file test/program_trace.txt");
            other_cnt++;
            aborted = 1'b1;
            return;
        end
        done = 1'b0;
        while (!done)
        begin
            n = $fscanf(fd, " %c", tag);
            if (n != 1)
                done = 1'b1;
            else if (tag == "#")
                skip_line(fd);
            else if (tag == "P" && $fscanf(fd, "%h %h", a, b) == 2)
            begin
                prog_adr_q.push_back(a);
                prog_word_q.push_back(b);
                skip_line(fd);
            end
            else if (tag == "L" && $fscanf(fd, "%h", a) == 1)
            begin
                led_exp_q.push_back(a);
                skip_line(fd);
            end
            else
            begin
                $display("Trace file has a line that cannot be read");
                other_cnt++;
                aborted = 1'b1;
                done = 1'b1;
            end
        end
        $fclose(fd);
        if (!aborted && (prog_word_q.size() == 0 || led_exp_q.size() == 0))
        begin
            $display("Trace file holds no program or no expected LED values");
            other_cnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (fpga_rst !== 1'b0 && cycles < RST_TIMEOUT)
        begin
            @(negedge fpga_clk);
            cycles++;
        end
        if (fpga_rst !== 1'b0)
        begin
            $display("Reset was never released");
            other_cnt++;
            aborted = 1'b1;
        end
    endtask

    // LED must sit at zero while the CPU is held for loading
    task automatic load_program();
        int idx;
        for (idx = 0; idx < prog_word_q.size(); idx++)
        begin
            @(posedge fpga_clk);
            prog_wen_i <= 1'b1;
            prog_adr_i <= prog_adr_q[idx][IMEM_ADR_W-1:0];
            prog_dat_i <= prog_word_q[idx];
            @(negedge fpga_clk);
            check_value(led_o, 32'h0, "LED during program load");
        end
        @(posedge fpga_clk);
        prog_wen_i <= 1'b0;
        @(posedge fpga_clk);
        prog_mode_i <= 1'b0;                                   // Release the CPU
    endtask

    task automatic follow_led();
        logic [23:0] last;
        int          cycles;
        int          idx;
        last = led_o;
        for (idx = 0; idx < led_exp_q.size() && !aborted; idx++)
        begin
            cycles = 0;
            while (led_o === last && cycles < CHANGE_TIMEOUT)
            begin
                @(negedge fpga_clk);
                cycles++;
            end
            if (led_o === last)
            begin
                $display("Timeout: LED value %0h (trace entry %0d) never arrived",
                         led_exp_q[idx], idx);
                timeout_cnt++;
                aborted = 1'b1;
            end
            else
            begin
                check_value(led_o, led_exp_q[idx], $sformatf("LED value %0d", idx));
                last = led_o;
            end
        end
    endtask

    task automatic check_led_steady();
        int cycle;
        for (cycle = 0; cycle < STEADY_CYCLES; cycle++)
        begin
            @(negedge fpga_clk);
            check_value(led_o, led_exp_q[led_exp_q.size()-1], "LED in spin loop");
        end
    endtask

    ////////////////////////////////////////////////////////////
    initial
    begin
        prog_mode_i = 1'b1;                                    // Hold CPU from time zero
        prog_wen_i  = 1'b0;
        prog_adr_i  = '0;
        prog_dat_i  = '0;
        read_trace();
        if (!aborted)
            wait_reset_release();
        if (!aborted)
            load_program();
        if (!aborted)
            follow_led();
        if (!aborted)
            check_led_steady();
        $display("Errors: %0d mismatches, %0d timeouts, %0d other",
                 mismatch_cnt, timeout_cnt, other_cnt);
        if (mismatch_cnt + timeout_cnt + other_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/program_trace.txt
# P <word address hex> <instruction hex>   loaded into instruction memory
# L <led value hex>                        next expected led_o value, in order
P 00 20010012   # addi r1, r0, 0x12
P 01 20220034   # addi r2, r1, 0x34
P 02 00221820   # add  r3, r1, r2
P 03 AC03FC60   # sw   r3, led
P 04 00612022   # sub  r4, r3, r1
P 05 AC04FC60   # sw   r4, led
P 06 3485FF00   # ori  r5, r4, 0xff00
P 07 30A60F0F   # andi r6, r5, 0x0f0f
P 08 AC06FC60   # sw   r6, led
P 09 0026382A   # slt  r7, r1, r6
P 0A AC07FC60   # sw   r7, led
P 0B 2008FFFB   # addi r8, r0, -5
P 0C 0028482A   # slt  r9, r1, r8
P 0D 01255025   # or   r10, r9, r5
P 0E AC0AFC60   # sw   r10, led
P 0F AC060010   # sw   r6, 0x10(r0)
P 10 8C0B0010   # lw   r11, 0x10(r0)
P 11 016B6020   # add  r12, r11, r11
P 12 AC0CFC60   # sw   r12, led
P 13 10210003   # beq  r1, r1, +3
P 14 AC01FC60   # sw   r1, led
P 15 AC02FC60   # sw   r2, led
P 16 AC03FC60   # sw   r3, led
P 17 200D0777   # addi r13, r0, 0x777
P 18 AC0DFC60   # sw   r13, led
P 19 14220003   # bne  r1, r2, +3
P 1A AC01FC60   # sw   r1, led
P 1B AC02FC60   # sw   r2, led
P 1C AC03FC60   # sw   r3, led
P 1D AC04FC60   # sw   r4, led
P 1E 10220003   # beq  r1, r2, +3
P 1F AC05FC60   # sw   r5, led
P 20 200E12AB   # addi r14, r0, 0x12ab
P 21 AC0EFC62   # sw   r14, led+2
P 22 1000FFFF   # beq  r0, r0, -1
P 23 00000000
P 24 00000000
P 25 00000000
L 000058
L 000046
L 000F06
L 000001
L 00FF46
L 001E0C
L 000777
L 000046
L 00FF46
L ABFF46

//--- list.f
common/mips_pkg.sv
fetch/ifetch.sv
decode/idecode.sv
execute/execute.sv
memory/mem_stage.sv
hw/led_port.sv
hw/mips_pipeline_top.sv
test/tb_clock.sv
test/tb_mips.sv
